/* edge_job_fetch.f */
hw/edge_fetch_pkg.sv
hw/vertex_intake.sv
hw/edge_read_planner.sv
hw/edge_line_unpacker.sv
hw/edge_job_fifo.sv
hw/edge_job_fetch.sv
verif/edge_job_fetch_tb.sv

/* hw/edge_fetch_pkg.sv */
package edge_fetch_pkg;

	//////////////////////////////////////////////////
	// Widths and sizes
	//////////////////////////////////////////////////

	// Byte address into the edge array
	localparam int ADDR_W   = 32;
	localparam int VERTEX_W = 16;
	localparam int DEGREE_W = 16;

	// One edge is a 32-bit destination word
	localparam int EDGE_BYTES = 4;
	localparam int EDGE_W     = 32;

	// Memory line geometry
	localparam int LINE_BYTES     = 64;
	localparam int EDGES_PER_LINE = 16;
	localparam int SLOT_W         = 4;
	localparam int COUNT_W        = 5;

	// Output buffer
	localparam int FIFO_DEPTH = 32;
	localparam int LEVEL_W    = 6;

	//////////////////////////////////////////////////
	// Job, command and response records
	//////////////////////////////////////////////////

	typedef struct packed {
		logic [VERTEX_W-1:0] id;
		logic [DEGREE_W-1:0] edges_idx;
		logic [DEGREE_W-1:0] out_degree;
	} vertex_job_t;

	// Travels with a read and comes back with its data
	typedef struct packed {
		logic [VERTEX_W-1:0] src;
		logic [DEGREE_W-1:0] edge_base;
		logic [SLOT_W-1:0]   first_slot;
		logic [COUNT_W-1:0]  count;
	} read_tag_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		read_tag_t         tag;
	} read_cmd_t;

	typedef struct packed {
		logic [LINE_BYTES*8-1:0] line;
		read_tag_t               tag;
	} read_resp_t;

	typedef struct packed {
		logic [DEGREE_W-1:0] id;
		logic [VERTEX_W-1:0] src;
		logic [EDGE_W-1:0]   dest;
	} edge_job_t;

	// Intake to planner, address already resolved
	typedef struct packed {
		logic [VERTEX_W-1:0] src;
		logic [ADDR_W-1:0]   addr;
		logic [DEGREE_W-1:0] out_degree;
	} vertex_work_t;

endpackage

/* hw/edge_job_fetch.sv */
`timescale 1ns/1ps

module edge_job_fetch (
	input  logic                                clock,
	input  logic                                rstn,
	input  logic [edge_fetch_pkg::ADDR_W-1:0]   edge_array_base,
	input  logic                                vertex_valid,
	output logic                                vertex_ready,
	input  edge_fetch_pkg::vertex_job_t         vertex,
	output logic                                cmd_valid,
	input  logic                                cmd_ready,
	output edge_fetch_pkg::read_cmd_t           cmd,
	input  logic                                resp_valid,
	output logic                                resp_ready,
	input  edge_fetch_pkg::read_resp_t          resp,
	output logic                                edge_valid,
	input  logic                                edge_ready,
	output edge_fetch_pkg::edge_job_t           edge_job
);

	// Intake to planner
	logic                         work_valid;
	logic                         work_ready;
	edge_fetch_pkg::vertex_work_t work;

	// Unpacker to planner and FIFO
	logic                      unpack_done;
	logic                      push;
	edge_fetch_pkg::edge_job_t push_data;

	// FIFO occupancy back to the planner
	logic [edge_fetch_pkg::LEVEL_W-1:0] level;

	//////////////////////////////////////////////////
	// Input side
	//////////////////////////////////////////////////

	vertex_intake u_vertex_intake (
		.clock          (clock),
		.rstn           (rstn),
		.edge_array_base(edge_array_base),
		.vertex_valid   (vertex_valid),
		.vertex_ready   (vertex_ready),
		.vertex         (vertex),
		.work_valid     (work_valid),
		.work_ready     (work_ready),
		.work           (work)
	);

	//////////////////////////////////////////////////
	// Read planning and line unpacking
	//////////////////////////////////////////////////

	edge_read_planner u_edge_read_planner (
		.clock      (clock),
		.rstn       (rstn),
		.work_valid (work_valid),
		.work_ready (work_ready),
		.work       (work),
		.cmd_valid  (cmd_valid),
		.cmd_ready  (cmd_ready),
		.cmd        (cmd),
		.unpack_done(unpack_done),
		.level      (level)
	);

	edge_line_unpacker u_edge_line_unpacker (
		.clock      (clock),
		.rstn       (rstn),
		.resp_valid (resp_valid),
		.resp_ready (resp_ready),
		.resp       (resp),
		.push       (push),
		.push_data  (push_data),
		.unpack_done(unpack_done)
	);

	//////////////////////////////////////////////////
	// Output side
	//////////////////////////////////////////////////

	edge_job_fifo u_edge_job_fifo (
		.clock     (clock),
		.rstn      (rstn),
		.push      (push),
		.push_data (push_data),
		.edge_valid(edge_valid),
		.edge_ready(edge_ready),
		.edge_job  (edge_job),
		.level     (level)
	);

endmodule

/* hw/edge_job_fifo.sv */
`timescale 1ns/1ps

module edge_job_fifo (
	input  logic                               clock,
	input  logic                               rstn,
	input  logic                               push,
	input  edge_fetch_pkg::edge_job_t          push_data,
	output logic                               edge_valid,
	input  logic                               edge_ready,
	output edge_fetch_pkg::edge_job_t          edge_job,
	output logic [edge_fetch_pkg::LEVEL_W-1:0] level
);

	edge_fetch_pkg::edge_job_t store [edge_fetch_pkg::FIFO_DEPTH];

	// Pointers wrap on their own, depth is a power of two
	logic [$clog2(edge_fetch_pkg::FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(edge_fetch_pkg::FIFO_DEPTH)-1:0] rd_ptr;
	logic                                          pop;

	assign edge_valid = (level != '0);
	assign pop        = edge_valid && edge_ready;
	assign edge_job   = store[rd_ptr];

	//////////////////////////////////////////////////
	// Pointers and occupancy
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: level <= level + 1'b1;
				2'b01: level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

	// Storage
	always_ff @(posedge clock) begin
		if (push) begin
			store[wr_ptr] <= push_data;
		end
	end

endmodule

/* hw/edge_line_unpacker.sv */
`timescale 1ns/1ps

module edge_line_unpacker (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       resp_valid,
	output logic                       resp_ready,
	input  edge_fetch_pkg::read_resp_t resp,
	output logic                       push,
	output edge_fetch_pkg::edge_job_t  push_data,
	output logic                       unpack_done
);

	logic                               busy;
	logic                               accept;
	logic                               last_push;
	logic [edge_fetch_pkg::SLOT_W-1:0]  slot;
	logic [edge_fetch_pkg::COUNT_W-1:0] pushed;

	// Line and tag of the read being unpacked
	edge_fetch_pkg::read_resp_t held_resp;

	//////////////////////////////////////////////////
	// Response intake
	//////////////////////////////////////////////////

	// Only one line in flight, so take data only when idle
	assign resp_ready = !busy;
	assign accept     = resp_valid && resp_ready;

	always_ff @(posedge clock) begin
		if (accept) begin
			held_resp <= resp;
		end
	end

	//////////////////////////////////////////////////
	// One edge per cycle
	//////////////////////////////////////////////////

	assign last_push = busy && (pushed == held_resp.tag.count - 1'b1);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy   <= 1'b0;
			slot   <= '0;
			pushed <= '0;
		end else if (accept) begin
			busy   <= 1'b1;
			slot   <= resp.tag.first_slot;
			pushed <= '0;
		end else if (busy) begin
			slot   <= slot + 1'b1;
			pushed <= pushed + 1'b1;
			if (last_push) begin
				busy <= 1'b0;
			end
		end
	end

	// Never stalled, the planner checked FIFO space before the read
	assign push        = busy;
	assign unpack_done = last_push;

	// Slot 0 sits in the low word of the line
	assign push_data.id   = held_resp.tag.edge_base + edge_fetch_pkg::DEGREE_W'(pushed);
	assign push_data.src  = held_resp.tag.src;
	assign push_data.dest = held_resp.line[slot*edge_fetch_pkg::EDGE_W +: edge_fetch_pkg::EDGE_W];

endmodule

/* hw/edge_read_planner.sv */
`timescale 1ns/1ps

module edge_read_planner (
	input  logic                               clock,
	input  logic                               rstn,
	input  logic                               work_valid,
	output logic                               work_ready,
	input  edge_fetch_pkg::vertex_work_t       work,
	output logic                               cmd_valid,
	input  logic                               cmd_ready,
	output edge_fetch_pkg::read_cmd_t          cmd,
	input  logic                               unpack_done,
	input  logic [edge_fetch_pkg::LEVEL_W-1:0] level
);

	typedef enum logic [1:0] {
		PLAN_IDLE,
		PLAN_ISSUE,
		PLAN_WAIT,
		PLAN_FINISH
	} plan_state_t;

	plan_state_t state;
	plan_state_t state_next;

	// Per-vertex progress
	logic [edge_fetch_pkg::DEGREE_W-1:0] remaining;
	logic [edge_fetch_pkg::ADDR_W-1:0]   next_addr;
	logic [edge_fetch_pkg::DEGREE_W-1:0] next_edge;

	// Current read
	logic [edge_fetch_pkg::ADDR_W-1:0]  line_ofs;
	logic [edge_fetch_pkg::SLOT_W-1:0]  first_slot;
	logic [edge_fetch_pkg::COUNT_W-1:0] room;
	logic [edge_fetch_pkg::COUNT_W-1:0] take_count;

	logic space_ok;
	logic load_work;
	logic start_read;

	//////////////////////////////////////////////////
	// Address and count for the next read
	//////////////////////////////////////////////////

	assign line_ofs   = next_addr % edge_fetch_pkg::LINE_BYTES;
	assign first_slot = edge_fetch_pkg::SLOT_W'(line_ofs / edge_fetch_pkg::EDGE_BYTES);
	assign room       = edge_fetch_pkg::COUNT_W'(edge_fetch_pkg::EDGES_PER_LINE)
		- edge_fetch_pkg::COUNT_W'(first_slot);

	// Bounded by the line and by the vertex
	assign take_count = (remaining < edge_fetch_pkg::DEGREE_W'(room))
		? edge_fetch_pkg::COUNT_W'(remaining) : room;

	// A whole line must fit in the FIFO before the read goes out
	assign space_ok = ((edge_fetch_pkg::LEVEL_W+1)'(level)
		+ (edge_fetch_pkg::LEVEL_W+1)'(edge_fetch_pkg::EDGES_PER_LINE))
		<= (edge_fetch_pkg::LEVEL_W+1)'(edge_fetch_pkg::FIFO_DEPTH);

	assign load_work  = (state == PLAN_IDLE) && work_valid && (remaining == '0);
	assign start_read = (state == PLAN_IDLE) && work_valid && (remaining != '0) && space_ok;

	assign cmd_valid  = (state == PLAN_ISSUE);
	assign work_ready = (state == PLAN_FINISH);

	//////////////////////////////////////////////////
	// FSM
	//////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			PLAN_IDLE: begin
				if (start_read) begin
					state_next = PLAN_ISSUE;
				end
			end
			PLAN_ISSUE: begin
				if (cmd_ready) begin
					state_next = PLAN_WAIT;
				end
			end
			PLAN_WAIT: begin
				if (unpack_done) begin
					state_next = (remaining == '0) ? PLAN_FINISH : PLAN_IDLE;
				end
			end
			default: begin
				state_next = PLAN_IDLE;
			end
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state     <= PLAN_IDLE;
			remaining <= '0;
		end else begin
			state <= state_next;
			if (load_work) begin
				remaining <= work.out_degree;
			end else if (start_read) begin
				remaining <= remaining - edge_fetch_pkg::DEGREE_W'(take_count);
			end
		end
	end

	// Command is built once and held until cmd_ready
	always_ff @(posedge clock) begin
		if (load_work) begin
			next_addr <= work.addr;
			next_edge <= '0;
		end else if (start_read) begin
			next_addr <= next_addr - line_ofs
				+ edge_fetch_pkg::ADDR_W'(edge_fetch_pkg::LINE_BYTES);
			next_edge <= next_edge + edge_fetch_pkg::DEGREE_W'(take_count);

			cmd.addr           <= next_addr - line_ofs;
			cmd.tag.src        <= work.src;
			cmd.tag.edge_base  <= next_edge;
			cmd.tag.first_slot <= first_slot;
			cmd.tag.count      <= take_count;
		end
	end

endmodule

/* hw/vertex_intake.sv */
`timescale 1ns/1ps

module vertex_intake (
	input  logic                              clock,
	input  logic                              rstn,
	input  logic [edge_fetch_pkg::ADDR_W-1:0] edge_array_base,
	input  logic                              vertex_valid,
	output logic                              vertex_ready,
	input  edge_fetch_pkg::vertex_job_t       vertex,
	output logic                              work_valid,
	input  logic                              work_ready,
	output edge_fetch_pkg::vertex_work_t      work
);

	logic                         held;
	logic                         take;
	logic                         empty_job;
	logic                         retire;
	edge_fetch_pkg::vertex_work_t held_work;

	// One vertex at a time
	assign vertex_ready = !held;
	assign take         = vertex_valid && vertex_ready;

	// Out-degree 0 never reaches the planner
	assign empty_job  = (held_work.out_degree == '0);
	assign work_valid = held && !empty_job;
	assign work       = held_work;

	// Empty vertex leaves on its own, the rest on work_ready
	assign retire = held && (empty_job || work_ready);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			held <= 1'b0;
		end else if (take) begin
			held <= 1'b1;
		end else if (retire) begin
			held <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// Byte address of the first edge
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (take) begin
			held_work.src        <= vertex.id;
			held_work.out_degree <= vertex.out_degree;
			held_work.addr       <= edge_array_base
				+ edge_fetch_pkg::ADDR_W'(vertex.edges_idx * edge_fetch_pkg::EDGE_BYTES);
		end
	end

endmodule

/* verif/edge_job_fetch_tb.sv */
`timescale 1ns/1ps

module edge_job_fetch_tb;

	localparam logic [31:0] EDGE_BASE = 32'h0010_0000;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
	localparam int          LIMIT     = 4000;
	localparam int          RANDOM_N  = 30;

	logic                              clock;
	logic                              rstn;
	logic [edge_fetch_pkg::ADDR_W-1:0] edge_array_base;
	logic                              vertex_valid;
	logic                              vertex_ready;
	edge_fetch_pkg::vertex_job_t       vertex;
	logic                              cmd_valid;
	logic                              cmd_ready;
	edge_fetch_pkg::read_cmd_t         cmd;
	logic                              resp_valid;
	logic                              resp_ready;
	edge_fetch_pkg::read_resp_t        resp;
	logic                              edge_valid;
	logic                              edge_ready;
	edge_fetch_pkg::edge_job_t         edge_job;

	logic [31:0]                 lfsr_state = 32'h1;
	edge_fetch_pkg::edge_job_t   expected_q[$];
	edge_fetch_pkg::vertex_job_t sent_q[$];
	edge_fetch_pkg::vertex_job_t random_jobs[RANDOM_N];
	// Edges requested so far, per source vertex
	int                          issued[int];

	edge_job_fetch u_edge_job_fetch (
		.clock          (clock),
		.rstn           (rstn),
		.edge_array_base(edge_array_base),
		.vertex_valid   (vertex_valid),
		.vertex_ready   (vertex_ready),
		.vertex         (vertex),
		.cmd_valid      (cmd_valid),
		.cmd_ready      (cmd_ready),
		.cmd            (cmd),
		.resp_valid     (resp_valid),
		.resp_ready     (resp_ready),
		.resp           (resp),
		.edge_valid     (edge_valid),
		.edge_ready     (edge_ready),
		.edge_job       (edge_job)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#20 clock = ~clock;
		end
	end

	//////////////////////////////////////////////////
	// Helpers and reference model
	//////////////////////////////////////////////////

	// Galois LFSR, one step per bit
	function automatic logic [31:0] lfsr_bits(input int width);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < width; i++) begin
			value      = {value[30:0], lfsr_state[0]};
			lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? LFSR_TAPS : 32'h0);
		end
		return value;
	endfunction

	// Edge array contents by word address
	function automatic logic [31:0] mem_word(input logic [31:0] word_addr);
		return (word_addr * 32'h9E37_79B1) ^ {word_addr[15:0], word_addr[31:16]}
			^ 32'hC3A5_5A3C;
	endfunction

	function automatic edge_fetch_pkg::edge_job_t expected_edge(
		input edge_fetch_pkg::vertex_job_t v, input int n);
		edge_fetch_pkg::edge_job_t e;
		e.id   = 16'(n);
		e.src  = v.id;
		e.dest = mem_word((EDGE_BASE >> 2) + 32'(v.edges_idx) + 32'(n));
		return e;
	endfunction

	function automatic int issued_count(input int src);
		return issued.exists(src) ? issued[src] : 0;
	endfunction

	function automatic edge_fetch_pkg::read_resp_t answer_read(
		input edge_fetch_pkg::read_cmd_t c);
		edge_fetch_pkg::read_resp_t r;
		for (int k = 0; k < edge_fetch_pkg::EDGES_PER_LINE; k++) begin
			r.line[k*32 +: 32] = mem_word(c.addr / 4 + 32'(k));
		end
		r.tag = c.tag;
		return r;
	endfunction

	task automatic fail_run;
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s is %0h, expected %0h",
				$time, name, actual, expected);
			fail_run();
		end
	endtask

	task automatic check_command(input edge_fetch_pkg::read_cmd_t c);
		check_value("cmd.addr line offset", c.addr % edge_fetch_pkg::LINE_BYTES, 0);
		check_value("cmd.tag.count in line", (c.tag.count != 0)
			&& (c.tag.count <= edge_fetch_pkg::EDGES_PER_LINE - c.tag.first_slot), 1);
		check_value("cmd.tag.edge_base", c.tag.edge_base, issued_count(c.tag.src));
		issued[c.tag.src] = issued_count(c.tag.src) + c.tag.count;
	endtask

	// Called 2 ns after a rising edge, returns at the same point
	task automatic send_vertex(input edge_fetch_pkg::vertex_job_t v);
		int waited;
		waited = 0;
		for (int n = 0; n < v.out_degree; n++) begin
			expected_q.push_back(expected_edge(v, n));
		end
		sent_q.push_back(v);
		vertex       = v;
		vertex_valid = 1'b1;
		@(negedge clock);
		while (!vertex_ready) begin
			waited++;
			if (waited > LIMIT) begin
				$display("Timeout: vertex %0d was never accepted", v.id);
				fail_run();
			end
			@(negedge clock);
		end
		@(posedge clock);
		#2;
		vertex_valid = 1'b0;
		vertex       = '0;
	endtask

	task automatic wait_for_drain;
		int waited;
		waited = 0;
		@(negedge clock);
		while (expected_q.size() != 0 || !vertex_ready) begin
			waited++;
			if (waited > LIMIT) begin
				$display("Timeout: %0d edges never arrived", expected_q.size());
				fail_run();
			end
			@(negedge clock);
		end
	endtask

	//////////////////////////////////////////////////
	// Memory model and ready drivers
	//////////////////////////////////////////////////

	initial begin
		edge_fetch_pkg::read_cmd_t held_cmd;
		logic                      cmd_fire;
		logic                      resp_fire;
		logic                      pending;
		int                        delay;
		int                        stretch;
		cmd_ready  = 1'b0;
		resp_valid = 1'b0;
		resp       = '0;
		edge_ready = 1'b0;
		pending    = 1'b0;
		delay      = 0;
		stretch    = 0;
		forever begin
			@(negedge clock);
			// One read in flight, so the unpacker is idle when data comes back
			if (resp_valid) begin
				check_value("resp_ready", resp_ready, 1);
			end
			cmd_fire  = cmd_valid && cmd_ready;
			resp_fire = resp_valid && resp_ready;
			if (cmd_fire) begin
				held_cmd = cmd;
				check_command(cmd);
				pending = 1'b1;
				delay   = lfsr_bits(3);
			end
			@(posedge clock);
			#2;
			cmd_ready = lfsr_bits(1);
			if (resp_fire) begin
				resp_valid = 1'b0;
			end
			if (pending && delay == 0) begin
				resp       = answer_read(held_cmd);
				resp_valid = 1'b1;
				pending    = 1'b0;
			end else if (pending) begin
				delay--;
			end
			// Long low stretches fill the FIFO
			if (stretch == 0) begin
				edge_ready = lfsr_bits(1);
				stretch    = edge_ready ? lfsr_bits(4) : lfsr_bits(6);
			end else begin
				stretch--;
			end
		end
	end

	//////////////////////////////////////////////////
	// Edge comparison
	//////////////////////////////////////////////////

	initial begin
		edge_fetch_pkg::edge_job_t want;
		forever begin
			@(negedge clock);
			if (edge_valid && edge_ready && expected_q.size() == 0) begin
				$display("Edge job from vertex %0d arrived with none expected", edge_job.src);
				fail_run();
			end else if (edge_valid && edge_ready) begin
				want = expected_q.pop_front();
				check_value("edge_job.id", edge_job.id, want.id);
				check_value("edge_job.src", edge_job.src, want.src);
				check_value("edge_job.dest", edge_job.dest, want.dest);
			end
		end
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial begin
		edge_fetch_pkg::vertex_job_t v;
		rstn            = 1'b0;
		edge_array_base = EDGE_BASE;
		vertex_valid    = 1'b0;
		vertex          = '0;
		// Random vertices drawn before the ready drivers start
		for (int i = 0; i < RANDOM_N; i++) begin
			random_jobs[i].id         = 16'(10 + i);
			random_jobs[i].edges_idx  = 16'(lfsr_bits(16));
			random_jobs[i].out_degree = 16'(lfsr_bits(6));
		end
		repeat (8) @(posedge clock);
		#2;
		rstn = 1'b1;
		@(negedge clock);
		check_value("vertex_ready after reset", vertex_ready, 1);
		check_value("cmd_valid after reset", cmd_valid, 0);
		check_value("edge_valid after reset", edge_valid, 0);
		@(posedge clock);
		#2;

		// Aligned, three lines
		v = '{id: 16'd1, edges_idx: 16'd0, out_degree: 16'd40};
		send_vertex(v);
		// Starts mid-line
		v = '{id: 16'd2, edges_idx: 16'd5, out_degree: 16'd17};
		send_vertex(v);
		// No edges, then a short vertex behind it
		v = '{id: 16'd3, edges_idx: 16'd100, out_degree: 16'd0};
		send_vertex(v);
		v = '{id: 16'd4, edges_idx: 16'd33, out_degree: 16'd3};
		send_vertex(v);
		foreach (random_jobs[i]) begin
			send_vertex(random_jobs[i]);
		end

		wait_for_drain();
		// Let the last edge transfer complete, then nothing may remain
		@(negedge clock);
		check_value("edge_valid after drain", edge_valid, 0);
		check_value("cmd_valid after drain", cmd_valid, 0);
		check_value("resp_ready after drain", resp_ready, 1);
		foreach (sent_q[i]) begin
			check_value($sformatf("sum of cmd counts for vertex %0d", sent_q[i].id),
				issued_count(sent_q[i].id), sent_q[i].out_degree);
		end
		$display("RESULT: PASS");
		$finish;
	end

endmodule
